// ==== caddr_consts.svh ====
// CADDR memory subsystem constants
// widths, access timing counts and RAM address regions

`ifndef CADDR_CONSTS_SVH
`define CADDR_CONSTS_SVH

`define WORD_W        32     // every memory port data word
`define SDRAM_ADDR_W  22     // main memory word address
`define VRAM_ADDR_W   15     // video memory word address
`define SRAM_ADDR_W   18     // static RAM word address
`define PC_W          14     // program counter on the display
`define RC_STATE_W    4      // controller state code

`define SRAM_WAIT     2      // cycles address is held before sample or write end
`define WAIT_W        2      // wait counter width
`define RESET_HOLD    16     // soft reset length after the reset button
`define HOLD_W        5      // reset hold counter width
`define SCAN_CYCLES   8      // cycles each display digit stays lit
`define SCAN_W        3      // scan counter width

`define VRAM_BASE_HI  3'b111 // top address bits of the video region

`endif

// ==== caddr_pkg.sv ====
// CADDR shared types
// width typedefs for the memory ports and the RAM controller state codes

`include "caddr_consts.svh"

package caddr_pkg;

   typedef logic [`WORD_W-1:0]       word_t;
   typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;
   typedef logic [`VRAM_ADDR_W-1:0]  vram_addr_t;
   typedef logic [`SRAM_ADDR_W-1:0]  sram_addr_t;
   typedef logic [`PC_W-1:0]         pc_t;

   // codes are fixed, the LEDs and display dots show them
   typedef enum logic [`RC_STATE_W-1:0] {
      RC_IDLE = 4'd0,
      RC_VGA  = 4'd1,   // refresh read accepted
      RC_VCPU = 4'd2,   // processor video access accepted
      RC_MAIN = 4'd3,   // main memory access accepted
      RC_HOLD = 4'd4,   // address held, write strobe window
      RC_DONE = 4'd5
   } rc_state_t;

endpackage

// ==== support.sv ====
// Board support sequencer
// synchronizes the four buttons and turns their rising edges into
// soft reset, boot, halt and interrupt

`include "caddr_consts.svh"

module support (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [3:0] button,     // 3 reset, 2 boot, 1 halt, 0 continue
   output logic       soft_reset,
   output logic       boot,
   output logic       halt,
   output logic       interrupt
);

   logic [3:0]         btn_meta;   // first synchronizer stage
   logic [3:0]         btn_sync;   // second synchronizer stage
   logic [3:0]         btn_prev;   // for edge detect
   logic [3:0]         btn_rise;
   logic [`HOLD_W-1:0] hold_cnt;   // soft reset cycles left

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
         btn_prev <= '0;
      end else begin
         btn_meta <= button;
         btn_sync <= btn_meta;
         btn_prev <= btn_sync;
      end
   end

   assign btn_rise = btn_sync & ~btn_prev;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hold_cnt <= '0;
      end else if (btn_rise[3]) begin
         hold_cnt <= `HOLD_W'(`RESET_HOLD);  // restart on every press
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

   assign soft_reset = (hold_cnt != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         boot      <= 1'b0;
         interrupt <= 1'b0;
         halt      <= 1'b0;
      end else begin
         boot      <= btn_rise[2];   // one cycle pulse
         interrupt <= btn_rise[0];
         if (btn_rise[1]) begin
            halt <= ~halt;            // each press flips the run state
         end
      end
   end

endmodule

// ==== board_config.sv ====
// Board configuration register
// samples the slide switches, gates video refresh from switch 7 and
// drives the status LEDs

module board_config import caddr_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [7:0] switches,
   input  rc_state_t  rc_state,
   input  logic       halt,
   input  logic       soft_reset,
   input  logic       sram_we_n,
   output logic       vga_enable,
   output logic [7:0] led
);

   logic [7:0] sw_meta;
   logic [7:0] sw_q;      // settled switch value

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sw_meta <= '0;
         sw_q    <= '0;
      end else begin
         sw_meta <= switches;
         sw_q    <= sw_meta;
      end
   end

   assign vga_enable = sw_q[7];   // refresh allowed

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         led <= '0;
      end else begin
         led <= {rc_state, vga_enable, halt, soft_reset, ~sram_we_n};
      end
   end

endmodule

// ==== ram_controller.sv ====
// Static RAM controller
// shares one 32-bit static RAM between main memory, processor video and
// video refresh with fixed priority, one access in flight at a time

`include "caddr_consts.svh"

module ram_controller import caddr_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        soft_reset,
   input  logic        vga_enable,

   input  sdram_addr_t sdram_addr,
   input  word_t       sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output word_t       sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,

   input  vram_addr_t  vram_cpu_addr,
   input  word_t       vram_cpu_data_in,
   input  logic        vram_cpu_req,
   input  logic        vram_cpu_write,
   output word_t       vram_cpu_data_out,
   output logic        vram_cpu_ready,
   output logic        vram_cpu_done,

   input  vram_addr_t  vram_vga_addr,
   input  logic        vram_vga_req,
   output word_t       vram_vga_data_out,
   output logic        vram_vga_ready,
   output logic        vram_vga_done,

   output sram_addr_t  sram_a,
   output word_t       sram_data_out,
   input  word_t       sram_data_in,
   output logic        sram_ce_n,
   output logic        sram_oe_n,
   output logic        sram_we_n,

   output rc_state_t   rc_state
);

   rc_state_t          state;
   rc_state_t          owner;      // port being served, RC_IDLE when none
   logic [`WAIT_W-1:0] wait_cnt;
   logic               wr_q;
   sram_addr_t         addr_q;
   word_t              data_q;
   logic               accept_ok;
   logic               grant_vga;
   logic               grant_cpu;
   logic               grant_main;
   logic               capture;

   // refresh first, then processor video, then main memory
   assign accept_ok  = (state == RC_IDLE) && !soft_reset;
   assign grant_vga  = accept_ok && vga_enable && vram_vga_req;
   assign grant_cpu  = accept_ok && !grant_vga && vram_cpu_req;
   assign grant_main = accept_ok && !grant_vga && !vram_cpu_req && sdram_req;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= RC_IDLE;
         owner    <= RC_IDLE;
         wait_cnt <= '0;
         wr_q     <= 1'b0;
      end else if (soft_reset) begin
         state    <= RC_IDLE;
         owner    <= RC_IDLE;
         wait_cnt <= '0;
         wr_q     <= 1'b0;
      end else begin
         case (state)
            RC_IDLE: begin
               wait_cnt <= `WAIT_W'(`SRAM_WAIT - 2);   // hold cycles after the first
               if (grant_vga) begin
                  state <= RC_VGA;
                  owner <= RC_VGA;
                  wr_q  <= 1'b0;
               end else if (grant_cpu) begin
                  state <= RC_VCPU;
                  owner <= RC_VCPU;
                  wr_q  <= vram_cpu_write;
               end else if (grant_main) begin
                  state <= RC_MAIN;
                  owner <= RC_MAIN;
                  wr_q  <= sdram_write;
               end
            end
            RC_VGA, RC_VCPU, RC_MAIN: begin
               state <= RC_HOLD;                     // address out for one cycle
            end
            RC_HOLD: begin
               if (wait_cnt == '0) begin
                  state <= RC_DONE;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            RC_DONE: begin
               state <= RC_IDLE;
               owner <= RC_IDLE;
            end
            default: begin
               state <= RC_IDLE;
               owner <= RC_IDLE;
            end
         endcase
      end
   end

   // latch the winner's address and write data on accept
   always_ff @(posedge clk) begin
      if (grant_vga) begin
         addr_q <= {`VRAM_BASE_HI, vram_vga_addr};
      end else if (grant_cpu) begin
         addr_q <= {`VRAM_BASE_HI, vram_cpu_addr};
         data_q <= vram_cpu_data_in;
      end else if (grant_main) begin
         addr_q <= {1'b0, sdram_addr[`SRAM_ADDR_W-2:0]};   // upper bits ignored
         data_q <= sdram_data_in;
      end
   end

   // sample at the end of the last hold cycle, valid while done is high
   assign capture = (state == RC_HOLD) && (wait_cnt == '0) && !wr_q;

   always_ff @(posedge clk) begin
      if (capture && owner == RC_VGA) begin
         vram_vga_data_out <= sram_data_in;
      end
      if (capture && owner == RC_VCPU) begin
         vram_cpu_data_out <= sram_data_in;
      end
      if (capture && owner == RC_MAIN) begin
         sdram_data_out <= sram_data_in;
      end
   end

   assign vram_vga_ready = grant_vga;
   assign vram_cpu_ready = grant_cpu;
   assign sdram_ready    = grant_main;

   assign vram_vga_done = (state == RC_DONE) && (owner == RC_VGA);
   assign vram_cpu_done = (state == RC_DONE) && (owner == RC_VCPU);
   assign sdram_done    = (state == RC_DONE) && (owner == RC_MAIN);

   assign sram_a        = addr_q;
   assign sram_data_out = data_q;
   assign sram_ce_n     = (state == RC_IDLE);
   assign sram_oe_n     = (state == RC_IDLE) || wr_q;    // low through a whole read
   assign sram_we_n     = !((state == RC_HOLD) && wr_q);

   assign rc_state = state;

endmodule

// ==== display.sv ====
// Seven-segment display scanner
// shows the program counter in hex on four multiplexed digits, with the
// decimal points carrying the RAM controller state bits

`include "caddr_consts.svh"

module display import caddr_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  pc_t        pc,
   input  rc_state_t  rc_state,
   output logic [7:0] sevenseg,      // bit 7 is the decimal point, active low
   output logic [3:0] sevenseg_an    // active low
);

   logic [`SCAN_W-1:0] scan_cnt;
   logic [1:0]         digit;        // digit being lit
   logic [3:0]         nibble;
   logic [3:0]         dots;
   logic [6:0]         seg;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scan_cnt <= '0;
         digit    <= '0;
      end else if (scan_cnt == `SCAN_W'(`SCAN_CYCLES - 1)) begin
         scan_cnt <= '0;
         digit    <= digit + 1'b1;
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   always_comb begin
      case (digit)
         2'd0:    nibble = pc[3:0];
         2'd1:    nibble = pc[7:4];
         2'd2:    nibble = pc[11:8];
         default: nibble = {2'b00, pc[13:12]};   // only two bits left
      endcase
   end

   // gfedcba, a segment is lit when its bit is low
   always_comb begin
      case (nibble)
         4'h0:    seg = 7'h40;
         4'h1:    seg = 7'h79;
         4'h2:    seg = 7'h24;
         4'h3:    seg = 7'h30;
         4'h4:    seg = 7'h19;
         4'h5:    seg = 7'h12;
         4'h6:    seg = 7'h02;
         4'h7:    seg = 7'h78;
         4'h8:    seg = 7'h00;
         4'h9:    seg = 7'h10;
         4'ha:    seg = 7'h08;
         4'hb:    seg = 7'h03;
         4'hc:    seg = 7'h46;
         4'hd:    seg = 7'h21;
         4'he:    seg = 7'h06;
         default: seg = 7'h0e;
      endcase
   end

   assign dots = rc_state;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sevenseg    <= 8'hff;
         sevenseg_an <= 4'hf;     // all digits dark
      end else begin
         sevenseg    <= {~dots[digit], seg};
         sevenseg_an <= ~(4'b0001 << digit);
      end
   end

endmodule

// ==== board_top.sv ====
// CADDR board top level
// memory and board support around the processor: buttons, switches,
// shared static RAM controller and the program counter display

module board_top import caddr_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [3:0]  button,
   input  logic [7:0]  switches,
   input  pc_t         pc,

   input  sdram_addr_t sdram_addr,
   input  word_t       sdram_data_in,
   input  logic        sdram_req,
   input  logic        sdram_write,
   output word_t       sdram_data_out,
   output logic        sdram_ready,
   output logic        sdram_done,

   input  vram_addr_t  vram_cpu_addr,
   input  word_t       vram_cpu_data_in,
   input  logic        vram_cpu_req,
   input  logic        vram_cpu_write,
   output word_t       vram_cpu_data_out,
   output logic        vram_cpu_ready,
   output logic        vram_cpu_done,

   input  vram_addr_t  vram_vga_addr,
   input  logic        vram_vga_req,
   output word_t       vram_vga_data_out,
   output logic        vram_vga_ready,
   output logic        vram_vga_done,

   output sram_addr_t  sram_a,
   output word_t       sram_data_out,
   input  word_t       sram_data_in,
   output logic        sram_ce_n,
   output logic        sram_oe_n,
   output logic        sram_we_n,

   output logic        boot,
   output logic        halt,
   output logic        interrupt,
   output logic        soft_reset,
   output logic [7:0]  led,
   output logic [7:0]  sevenseg,
   output logic [3:0]  sevenseg_an
);

   rc_state_t rc_state;
   logic      vga_enable;    // switch 7, refresh allowed

   support i_support (
      .clk        (clk),
      .arst_n     (arst_n),
      .button     (button),
      .soft_reset (soft_reset),
      .boot       (boot),
      .halt       (halt),
      .interrupt  (interrupt)
   );

   board_config i_board_config (
      .clk        (clk),
      .arst_n     (arst_n),
      .switches   (switches),
      .rc_state   (rc_state),
      .halt       (halt),
      .soft_reset (soft_reset),
      .sram_we_n  (sram_we_n),
      .vga_enable (vga_enable),
      .led        (led)
   );

   ram_controller i_ram_controller (
      .clk               (clk),
      .arst_n            (arst_n),
      .soft_reset        (soft_reset),
      .vga_enable        (vga_enable),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready),
      .vram_vga_done     (vram_vga_done),
      .sram_a            (sram_a),
      .sram_data_out     (sram_data_out),
      .sram_data_in      (sram_data_in),
      .sram_ce_n         (sram_ce_n),
      .sram_oe_n         (sram_oe_n),
      .sram_we_n         (sram_we_n),
      .rc_state          (rc_state)
   );

   display i_display (
      .clk         (clk),
      .arst_n      (arst_n),
      .pc          (pc),
      .rc_state    (rc_state),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

endmodule

// ==== tb_clock.sv ====
// Testbench clock source
// free running 4 ns clock for the board testbench

module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
   end

   always #2 clk = ~clk;   // 4 ns period

endmodule

// ==== tb_board_top.sv ====
// Board top level testbench
// walks a stimulus table through memory access, arbitration, refresh
// gating, buttons and display, with a behavioral static RAM model

`include "caddr_consts.svh"

module tb_board_top import caddr_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int P_MAIN = 0;
   localparam int P_VCPU = 1;
   localparam int P_VGA  = 2;
   localparam int K_ACCESS  = 0;
   localparam int K_CONTEND = 1;
   localparam int K_GATE    = 2;
   localparam int K_BUTTONS = 3;
   localparam int K_DISPLAY = 4;
   localparam int NUM_ENTRIES = 11;

   typedef struct {
      string       name;
      int          kind;
      int          port;
      logic        wr;
      sdram_addr_t addr;
      word_t       data;
      logic [7:0]  sw;
      pc_t         pc;
      logic [3:0]  btn;
   } entry_t;

   logic        clk;
   logic        arst_n;
   logic [3:0]  button;
   logic [7:0]  switches;
   pc_t         pc;
   sdram_addr_t sdram_addr;
   word_t       sdram_data_in;
   logic        sdram_req;
   logic        sdram_write;
   word_t       sdram_data_out;
   logic        sdram_ready;
   logic        sdram_done;
   vram_addr_t  vram_cpu_addr;
   word_t       vram_cpu_data_in;
   logic        vram_cpu_req;
   logic        vram_cpu_write;
   word_t       vram_cpu_data_out;
   logic        vram_cpu_ready;
   logic        vram_cpu_done;
   vram_addr_t  vram_vga_addr;
   logic        vram_vga_req;
   word_t       vram_vga_data_out;
   logic        vram_vga_ready;
   logic        vram_vga_done;
   sram_addr_t  sram_a;
   word_t       sram_data_out;
   word_t       sram_data_in;
   logic        sram_ce_n;
   logic        sram_oe_n;
   logic        sram_we_n;
   logic        boot;
   logic        halt;
   logic        interrupt;
   logic        soft_reset;
   logic [7:0]  led;
   logic [7:0]  sevenseg;
   logic [3:0]  sevenseg_an;

   word_t  ram [0:(1 << `SRAM_ADDR_W) - 1];   // static RAM model
   word_t  ref_mem [sram_addr_t];             // expected RAM contents
   entry_t stim [NUM_ENTRIES];
   int     n_entries;

   tb_clock i_tb_clock (.clk(clk));

   board_top i_board_top (.*);

   assign sram_data_in = !sram_oe_n ? ram[sram_a] : '0;

   always @(posedge sram_we_n) begin
      if (arst_n) begin
         ram[sram_a] <= sram_data_out;   // write lands as the strobe ends
      end
   end

   task automatic fail_run();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(string name, word_t exp, word_t act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_state(string name, rc_state_t exp, rc_state_t act);
      if (act !== exp) begin
         $display("ERR %s expected %0d actual %0d", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_seg(string name, logic [7:0] exp, logic [7:0] act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("ERR %s expected %b actual %b", name, exp, act);
         fail_run();
      end
   endtask

   // RAM word address a port access should reach
   function automatic sram_addr_t map_addr(int p, sdram_addr_t a);
      if (p == P_MAIN) begin
         return {1'b0, a[16:0]};
      end
      return {`VRAM_BASE_HI, a[14:0]};
   endfunction

   // active low gfedcba hex patterns
   function automatic logic [6:0] hex_segments(logic [3:0] n);
      logic [6:0] tbl [16];
      tbl = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
              7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
      return tbl[n];
   endfunction

   function automatic logic ready_of(int p);
      if (p == P_MAIN) return sdram_ready;
      if (p == P_VCPU) return vram_cpu_ready;
      return vram_vga_ready;
   endfunction

   function automatic logic done_of(int p);
      if (p == P_MAIN) return sdram_done;
      if (p == P_VCPU) return vram_cpu_done;
      return vram_vga_done;
   endfunction

   function automatic word_t data_of(int p);
      if (p == P_MAIN) return sdram_data_out;
      if (p == P_VCPU) return vram_cpu_data_out;
      return vram_vga_data_out;
   endfunction

   task automatic next_drive();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_cycles(int n);
      repeat (n) next_drive();
   endtask

   task automatic drive_port(int p, logic req, logic wr, sdram_addr_t a, word_t d);
      case (p)
         P_MAIN: begin
            sdram_req     = req;
            sdram_write   = wr;
            sdram_addr    = a;
            sdram_data_in = d;
         end
         P_VCPU: begin
            vram_cpu_req     = req;
            vram_cpu_write   = wr;
            vram_cpu_addr    = a[14:0];
            vram_cpu_data_in = d;
         end
         default: begin
            vram_vga_req  = req;
            vram_vga_addr = a[14:0];
         end
      endcase
   endtask

   // called in the done cycle of an access
   task automatic complete(string name, int p, logic wr, sdram_addr_t a, word_t d);
      sram_addr_t m;
      m = map_addr(p, a);
      if (wr) begin
         ref_mem[m] = d;
         check_word({name, " ram"}, d, ram[m]);
      end else if (!ref_mem.exists(m)) begin
         $display("%s reads a RAM word that no test wrote", name);
         fail_run();
      end else begin
         check_word({name, " data"}, ref_mem[m], data_of(p));
      end
   endtask

   task automatic add_entry(string name, int kind, int port, logic wr, sdram_addr_t addr,
                            word_t data, logic [7:0] sw, pc_t pcv, logic [3:0] btn);
      stim[n_entries].name = name;
      stim[n_entries].kind = kind;
      stim[n_entries].port = port;
      stim[n_entries].wr   = wr;
      stim[n_entries].addr = addr;
      stim[n_entries].data = data;
      stim[n_entries].sw   = sw;
      stim[n_entries].pc   = pcv;
      stim[n_entries].btn  = btn;
      n_entries++;
   endtask

   task automatic build_table();
      n_entries = 0;
      add_entry("main_wr", K_ACCESS, P_MAIN, 1'b1, 22'h000123, 32'hdeadbeef, 8'h80, '0, '0);
      add_entry("main_rd", K_ACCESS, P_MAIN, 1'b0, 22'h000123, '0, 8'h80, '0, '0);
      add_entry("vcpu_wr", K_ACCESS, P_VCPU, 1'b1, 22'h000456, 32'h12345678, 8'h80, '0, '0);
      add_entry("vga_rd", K_ACCESS, P_VGA, 1'b0, 22'h000456, '0, 8'h80, '0, '0);
      add_entry("main_hi_wr", K_ACCESS, P_MAIN, 1'b1, 22'h100001, 32'hcafef00d, 8'h80,
                '0, '0);
      add_entry("main_lo_rd", K_ACCESS, P_MAIN, 1'b0, 22'h000001, '0, 8'h80, '0, '0);
      add_entry("contend_wr", K_CONTEND, P_VGA, 1'b1, 22'h000456, word_t'($urandom()),
                8'h80, '0, '0);
      add_entry("contend_rd", K_CONTEND, P_VGA, 1'b0, 22'h000456, '0, 8'h80, '0, '0);
      add_entry("refresh_gate", K_GATE, P_MAIN, 1'b0, 22'h000123, '0, 8'h00, '0, '0);
      add_entry("buttons", K_BUTTONS, P_MAIN, 1'b0, '0, '0, 8'h80, '0, 4'hf);
      add_entry("display", K_DISPLAY, P_MAIN, 1'b0, '0, '0, 8'h80, 14'h2a5c, '0);
   endtask

   task automatic run_access(entry_t e);
      int lat;
      next_drive();
      drive_port(e.port, 1'b1, e.wr, e.addr, e.data);
      do @(negedge clk); while (!ready_of(e.port));
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
         check_bit({e.name, " ram ce"}, 1'b0, sram_ce_n);
         check_bit({e.name, " ram oe"}, e.wr, sram_oe_n);
         check_bit({e.name, " ram we"}, !(e.wr && lat == 2), sram_we_n);   // hold cycle only
      end while (!done_of(e.port));
      check_word({e.name, " latency"}, 32'd3, word_t'(lat));
      check_bit({e.name, " led write"}, e.wr, led[0]);
      complete(e.name, e.port, e.wr, e.addr, e.data);
      next_drive();
      drive_port(e.port, 1'b0, 1'b0, '0, '0);
      wait_cycles(2);
      @(negedge clk);
      check_state({e.name, " idle"}, RC_IDLE, rc_state_t'(led[7:4]));
   endtask

   task automatic run_contend(entry_t e);
      word_t      d [3];
      logic [2:0] pending;
      logic [2:0] finished;
      int         order [$];
      int         exp_order [3];
      d[P_MAIN] = {e.data[15:0], e.data[31:16]};
      d[P_VCPU] = e.data;
      d[P_VGA]  = '0;
      exp_order = '{P_VGA, P_VCPU, P_MAIN};
      next_drive();
      for (int p = 0; p < 3; p++) begin
         drive_port(p, 1'b1, (p == P_VGA) ? 1'b0 : e.wr, e.addr, d[p]);
      end
      pending = 3'b111;
      while (pending != 3'b000) begin
         @(negedge clk);
         finished = 3'b000;
         for (int p = 0; p < 3; p++) begin
            if (pending[p] && done_of(p)) begin
               order.push_back(p);
               complete(e.name, p, (p == P_VGA) ? 1'b0 : e.wr, e.addr, d[p]);
               finished[p] = 1'b1;
            end
         end
         pending = pending & ~finished;
         if (finished != 3'b000) begin
            next_drive();   // requester drops req the cycle after done
            for (int p = 0; p < 3; p++) begin
               if (finished[p]) drive_port(p, 1'b0, 1'b0, '0, '0);
            end
         end
      end
      for (int i = 0; i < 3; i++) begin
         check_word({e.name, " order"}, word_t'(exp_order[i]), word_t'(order[i]));
      end
   endtask

   task automatic run_gate(entry_t e);
      next_drive();
      switches = e.sw;
      wait_cycles(5);
      @(negedge clk);
      check_bit({e.name, " led vga"}, 1'b0, led[3]);
      next_drive();
      drive_port(P_VGA, 1'b1, 1'b0, e.addr, '0);
      drive_port(P_MAIN, 1'b1, 1'b0, e.addr, '0);
      do begin
         @(negedge clk);
         check_bit({e.name, " refresh ready"}, 1'b0, vram_vga_ready);
      end while (!sdram_done);
      complete(e.name, P_MAIN, 1'b0, e.addr, '0);
      next_drive();
      drive_port(P_VGA, 1'b0, 1'b0, '0, '0);
      drive_port(P_MAIN, 1'b0, 1'b0, '0, '0);
      switches = 8'h80;
      wait_cycles(5);
      @(negedge clk);
      check_bit({e.name, " led vga"}, 1'b1, led[3]);
   endtask

   task automatic count_pulses(int b, output int cnt);
      next_drive();
      button[b] = 1'b1;
      cnt = 0;
      repeat (10) begin
         @(negedge clk);
         if ((b == 2) ? boot : interrupt) cnt++;
      end
      next_drive();
      button[b] = 1'b0;
      wait_cycles(4);
   endtask

   task automatic run_buttons(entry_t e);
      int cnt;
      int i;
      if (e.btn[3]) begin
         next_drive();
         button[3] = 1'b1;
         i = 0;
         do begin
            @(negedge clk);
            i++;
         end while (!soft_reset && i < 8);
         if (!soft_reset) begin
            $display("soft reset never rose after the reset button press");
            fail_run();
         end
         cnt = 0;
         while (soft_reset) begin
            cnt++;
            if (cnt > 1) begin
               check_bit({e.name, " led soft reset"}, 1'b1, led[1]);   // one cycle behind
            end
            @(negedge clk);
         end
         check_word({e.name, " reset hold"}, `RESET_HOLD, word_t'(cnt));
         next_drive();
         button[3] = 1'b0;
         wait_cycles(4);
      end
      if (e.btn[1]) begin
         for (int k = 1; k <= 2; k++) begin
            next_drive();
            button[1] = 1'b1;
            wait_cycles(6);
            button[1] = 1'b0;
            @(negedge clk);
            check_bit({e.name, " halt"}, k == 1, halt);
            check_bit({e.name, " led halt"}, k == 1, led[2]);
         end
      end
      if (e.btn[2]) begin
         count_pulses(2, cnt);
         check_word({e.name, " boot pulses"}, 32'd1, word_t'(cnt));
      end
      if (e.btn[0]) begin
         count_pulses(0, cnt);
         check_word({e.name, " interrupt pulses"}, 32'd1, word_t'(cnt));
      end
   endtask

   task automatic run_display(entry_t e);
      logic [3:0] an;
      logic [3:0] seen;
      logic [3:0] nib;
      int         dg;
      next_drive();
      pc = e.pc;
      wait_cycles(3);
      seen = '0;
      repeat (4 * `SCAN_CYCLES * 2) begin
         @(negedge clk);
         an = sevenseg_an;
         check_bit({e.name, " one anode"}, 1'b1, $countones(~an) == 1);
         dg = 0;
         for (int d = 0; d < 4; d++) begin
            if (!an[d]) dg = d;
         end
         nib = (dg == 3) ? {2'b00, e.pc[13:12]} : e.pc[dg*4 +: 4];
         check_seg({e.name, " segments"}, {1'b1, hex_segments(nib)}, sevenseg);  // dot off
         seen[dg] = 1'b1;
      end
      check_bit({e.name, " all digits lit"}, 1'b1, seen == 4'hf);
   endtask

   initial begin
      repeat (NUM_ENTRIES * 200 + 20) @(posedge clk);
      $display("watchdog expired before the test table finished");
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      void'($urandom(32'hafe1));
      arst_n           = 1'b0;
      button           = '0;
      switches         = 8'h80;
      pc               = '0;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      sdram_req        = 1'b0;
      sdram_write      = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req     = 1'b0;
      vram_cpu_write   = 1'b0;
      vram_vga_addr    = '0;
      vram_vga_req     = 1'b0;
      build_table();
      repeat (10) @(posedge clk);
      #1;
      arst_n = 1'b1;
      wait_cycles(5);
      @(negedge clk);
      check_bit("reset led vga", 1'b1, led[3]);
      check_bit("reset soft reset", 1'b0, soft_reset);
      check_bit("reset ram ce", 1'b1, sram_ce_n);
      check_bit("reset ram oe", 1'b1, sram_oe_n);
      check_bit("reset ram we", 1'b1, sram_we_n);
      for (int i = 0; i < n_entries; i++) begin
         case (stim[i].kind)
            K_ACCESS:  run_access(stim[i]);
            K_CONTEND: run_contend(stim[i]);
            K_GATE:    run_gate(stim[i]);
            K_BUTTONS: run_buttons(stim[i]);
            default:   run_display(stim[i]);
         endcase
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+.
caddr_pkg.sv
support.sv
board_config.sv
ram_controller.sv
display.sv
board_top.sv
tb_clock.sv
tb_board_top.sv

// ==== Makefile ====
# Verilator build and run for the board testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/100ps
FILELIST  ?= sources.f

SRCS := $(filter-out +incdir%,$(shell cat $(FILELIST)))
HDRS := caddr_consts.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
